//--- Bender.yml
package:
  name: idct

sources:
  - files:
      - hw/idct_pkg.sv
      - hw/block_ram.sv
      - hw/block_fetch.sv
      - hw/idct_core.sv
      - hw/pixel_writer.sv
      - hw/idct_top.sv
  - target: simulation
    files:
      - dv/clock_gen.sv
      - dv/sram_model.sv
      - dv/tb_idct.sv

//--- dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic CLOCK,
    output logic Resetn
);

    initial begin
        CLOCK = 1'b0;
        forever #(PERIOD_NS / 2.0) CLOCK = ~CLOCK;
    end

    // reset leaves off the clock edge, like every other input
    initial begin
        Resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLOCK);
        #1 Resetn = 1'b1;
    end

endmodule

//--- dv/sram_model.sv
`timescale 1ns/1ps

module sram_model (
    input  logic                  CLOCK,
    input  idct_pkg::sram_req_t   req,
    output idct_pkg::sram_word_u  read_data
);

    logic [15:0]           mem [0:(1 << 18) - 1];   // filled by the testbench
    idct_pkg::sram_addr_t  addr_q;                  // first stage of the read

    initial begin
        addr_q    = '0;
        read_data = '0;
    end

    // address sampled on one edge, data out on the next
    always @(posedge CLOCK) begin
        addr_q    <= req.address;
        read_data <= mem[addr_q];
        if (!req.we_n)
            mem[req.address] <= req.write_data;
    end

endmodule

//--- dv/tb_idct.sv
`timescale 1ns/1ps

module tb_idct;

    localparam int ROW_STRIDE  = 320;
    localparam int NUM_TESTS   = 11;   // reset check plus ten blocks
    localparam int CYCLE_LIMIT = NUM_TESTS * 2000;
    localparam int DONE_LIMIT  = 2000;

    logic                  CLOCK;
    logic                  Resetn;
    logic                  start;
    idct_pkg::sram_addr_t  coeff_base;
    idct_pkg::sram_addr_t  pixel_base;
    idct_pkg::sram_word_u  sram_read_data;
    idct_pkg::sram_req_t   sram_req;
    logic                  done;

    int          error_count = 0;
    int          check_total = 0;
    int          write_count = 0;
    int          done_count  = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state   = 32'hafca;
    int          coeffs   [64];   // S' row-major
    logic [7:0]  expected [64];   // model pixels row-major

    clock_gen clock_gen_inst (.CLOCK(CLOCK), .Resetn(Resetn));

    sram_model sram_model_inst (.CLOCK(CLOCK), .req(sram_req), .read_data(sram_read_data));

    idct_top #(.ROW_STRIDE(ROW_STRIDE), .READ_LATENCY(2)) idct_top_inst (
        .CLOCK          (CLOCK),
        .Resetn         (Resetn),
        .start          (start),
        .coeff_base     (coeff_base),
        .pixel_base     (pixel_base),
        .sram_read_data (sram_read_data),
        .sram_req       (sram_req),
        .done           (done)
    );

    // mid-cycle sampling of the SRAM port and done
    always @(negedge CLOCK) begin
        if (Resetn && !sram_req.we_n)
            write_count++;
        if (Resetn && done)
            done_count++;
    end

    always @(posedge CLOCK) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] fill_pattern(input idct_pkg::sram_addr_t a);
        return {a[17:16] ^ a[15:14], a[13:0]} ^ 16'h5a3c;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge CLOCK);
            #1;
        end
    endtask

    task automatic check_pixels(input idct_pkg::pixel_pair_t got,
                                input idct_pkg::pixel_pair_t exp, input string what);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t: %s got %0d/%0d expected %0d/%0d",
                     $time, what, got.left, got.right, exp.left, exp.right);
        end
    endtask

    task automatic check_word(input idct_pkg::sram_word_u got,
                              input idct_pkg::sram_word_u exp, input string what);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t: %s got %04h expected %04h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        check_total++;
        if (got != exp) begin
            error_count++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // two passes with the shared cosine table, then clip to a byte
    task automatic compute_reference();
        int t_mat [64];
        int sum;
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                sum = 0;
                for (int k = 0; k < 8; k++)
                    sum += coeffs[r*8+k] * int'(idct_pkg::COS_TABLE[k*8+c]);
                t_mat[r*8+c] = sum >>> idct_pkg::T_SHIFT;
            end
        end
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                sum = 0;
                for (int k = 0; k < 8; k++)
                    sum += int'(idct_pkg::COS_TABLE[k*8+r]) * t_mat[k*8+c];
                sum = sum >>> idct_pkg::S_SHIFT;
                expected[r*8+c] = (sum < 0) ? 8'd0 : (sum > 255) ? 8'd255 : 8'(sum);
            end
        end
    endtask

    task automatic set_dc(input int value);
        foreach (coeffs[i])
            coeffs[i] = 0;
        coeffs[0] = value;
    endtask

    task automatic randomize_coeffs();
        foreach (coeffs[i]) begin
            rng_state = xorshift32(rng_state);
            coeffs[i] = int'(rng_state % 32'd1025) - 512;   // -512..512
        end
    endtask

    task automatic load_block(input idct_pkg::sram_addr_t base);
        for (int r = 0; r < 8; r++)
            for (int c = 0; c < 8; c++)
                sram_model_inst.mem[int'(base) + r*ROW_STRIDE + c] = 16'(coeffs[r*8+c]);
        compute_reference();
    endtask

    task automatic check_block(input idct_pkg::sram_addr_t base, input string name);
        idct_pkg::pixel_pair_t exp;
        int addr;
        for (int r = 0; r < 8; r++) begin
            for (int j = 0; j < 4; j++) begin
                addr      = int'(base) + r*ROW_STRIDE + j;
                exp.left  = expected[r*8+2*j];
                exp.right = expected[r*8+2*j+1];
                check_pixels(idct_pkg::pixel_pair_t'(sram_model_inst.mem[addr]), exp,
                             $sformatf("%s row %0d pair %0d", name, r, j));
            end
        end
    endtask

    task automatic check_untouched(input int addr);
        check_word(idct_pkg::sram_word_u'(sram_model_inst.mem[addr]),
                   idct_pkg::sram_word_u'(fill_pattern(idct_pkg::sram_addr_t'(addr))),
                   $sformatf("word %05h", addr));
    endtask

    task automatic pulse_start();
        start = 1'b1;
        wait_cycles(1);
        start = 1'b0;
    endtask

    task automatic wait_for_done(input string name);
        int waited;
        waited = 0;
        while (done !== 1'b1 && waited < DONE_LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        if (done !== 1'b1) begin
            error_count++;
            $display("%s: no done pulse within %0d cycles of start", name, DONE_LIMIT);
        end
    endtask

    // coeffs already set; one start, one done, 32 writes
    task automatic run_block(input idct_pkg::sram_addr_t cbase,
                             input idct_pkg::sram_addr_t pbase, input string name);
        int writes_before;
        int dones_before;
        load_block(cbase);
        coeff_base    = cbase;
        pixel_base    = pbase;
        writes_before = write_count;
        dones_before  = done_count;
        pulse_start();
        wait_for_done(name);
        wait_cycles(2);   // let the monitor see the done pulse
        check_count(write_count - writes_before, 32, {name, " writes"});
        check_count(done_count - dones_before, 1, {name, " done pulses"});
        check_block(pbase, name);
    endtask

    task automatic test_reset_state();
        for (int i = 0; i < 20; i++) begin
            check_flag(sram_req.we_n, 1'b1, "we_n after reset");
            check_flag(done, 1'b0, "done after reset");
            wait_cycles(1);
        end
        check_count(write_count, 0, "writes before start");
    endtask

    task automatic test_dc_block();
        set_dc(4000);
        run_block(18'h00000, 18'h01000, "dc block");
    endtask

    task automatic test_random_blocks();
        for (int b = 0; b < 5; b++) begin
            randomize_coeffs();
            run_block(18'h00000, 18'h01000, $sformatf("random block %0d", b));
        end
    endtask

    task automatic test_clipping();
        set_dc(30000);
        run_block(18'h00000, 18'h01000, "clip high");
        set_dc(-30000);
        run_block(18'h00000, 18'h01000, "clip low");
    endtask

    task automatic test_addressing();
        int pbase;
        pbase = 'h3a005;
        randomize_coeffs();
        run_block(18'h21234, 18'h3a005, "moved block");
        for (int r = -1; r <= 8; r++) begin
            check_untouched(pbase + r*ROW_STRIDE - 1);
            check_untouched(pbase + r*ROW_STRIDE + 4);
            if (r == -1 || r == 8) begin
                for (int j = 0; j < 4; j++)
                    check_untouched(pbase + r*ROW_STRIDE + j);
            end
        end
    endtask

    // a restart would reload coefficients from a different region mid-pass
    task automatic test_busy_start();
        int writes_before;
        int dones_before;
        randomize_coeffs();
        load_block(18'h00000);
        coeff_base    = 18'h00000;
        pixel_base    = 18'h02000;
        writes_before = write_count;
        dones_before  = done_count;
        pulse_start();
        wait_cycles(300);
        coeff_base = 18'h10000;
        pulse_start();
        wait_for_done("busy start");
        wait_cycles(100);
        check_count(write_count - writes_before, 32, "busy start writes");
        check_count(done_count - dones_before, 1, "busy start done pulses");
        check_block(18'h02000, "busy start");
    endtask

    initial begin
        start      = 1'b0;
        coeff_base = '0;
        pixel_base = '0;
        for (int a = 0; a < (1 << 18); a++)
            sram_model_inst.mem[a] = fill_pattern(idct_pkg::sram_addr_t'(a));
        @(posedge Resetn);
        wait_cycles(1);
        test_reset_state();
        test_dc_block();
        test_random_blocks();
        test_clipping();
        test_addressing();
        test_busy_start();
        $display("%0d checks, %0d errors", check_total, error_count);
        if (error_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- hw/block_fetch.sv
`timescale 1ns/1ps

module block_fetch #(
    parameter int ROW_STRIDE   = 320,
    parameter int READ_LATENCY = 2
) (
    input  logic                  CLOCK,
    input  logic                  Resetn,
    input  logic                  start,
    input  idct_pkg::sram_addr_t  coeff_base,
    input  idct_pkg::sram_word_u  sram_read_data,
    output idct_pkg::sram_req_t   fetch_req,
    output logic                  wr_en,
    output idct_pkg::ram_addr_t   wr_addr,
    output idct_pkg::coeff_t      wr_data,
    output logic                  block_loaded
);

    // cycles from an accepted start to the done pulse of the writer
    // reads plus read latency plus two passes of 10 cycles per output plus 3 of handoff
    localparam int HOLD_CYCLES = idct_pkg::BLOCK_WORDS + READ_LATENCY
                               + 2 * idct_pkg::BLOCK_WORDS * (idct_pkg::BLOCK_DIM + 2) + 3;
    localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);
    localparam idct_pkg::ram_addr_t LAST_IDX = idct_pkg::ram_addr_t'(idct_pkg::BLOCK_WORDS - 1);

    logic                 reading;                   // read burst in progress
    idct_pkg::ram_addr_t  idx;                       // row in [5:3], column in [2:0]
    logic [HOLD_W-1:0]    hold_cnt;
    logic                 busy;
    logic                 pipe_valid [1:READ_LATENCY];
    idct_pkg::ram_addr_t  pipe_idx   [1:READ_LATENCY];

    assign busy = (hold_cnt != '0);

    always_comb begin
        fetch_req.address    = coeff_base
                             + idct_pkg::sram_addr_t'(idx[5:3] * ROW_STRIDE)
                             + idct_pkg::sram_addr_t'(idx[2:0]);
        fetch_req.write_data = '0;
        fetch_req.we_n       = 1'b1;   // fetch only ever reads
    end

    // datum for the oldest stage is on the bus now
    assign wr_en   = pipe_valid[READ_LATENCY];
    assign wr_addr = pipe_idx[READ_LATENCY];
    assign wr_data = sram_read_data.coeff;

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            reading      <= 1'b0;
            idx          <= '0;
            hold_cnt     <= '0;
            block_loaded <= 1'b0;
            for (int i = 1; i <= READ_LATENCY; i++) begin
                pipe_valid[i] <= 1'b0;
            end
        end else begin
            block_loaded  <= wr_en && (wr_addr == LAST_IDX);
            pipe_valid[1] <= reading;
            for (int i = 2; i <= READ_LATENCY; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end

            if (reading) begin
                idx <= idx + 1'b1;   // wraps back to 0 after the last column
                if (idx == LAST_IDX)
                    reading <= 1'b0;
            end

            if (start && !busy) begin
                reading  <= 1'b1;
                idx      <= '0;
                hold_cnt <= HOLD_W'(HOLD_CYCLES);
            end else if (busy) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    // buffer index follows its read through the SRAM latency
    always_ff @(posedge CLOCK) begin
        pipe_idx[1] <= idx;
        for (int i = 2; i <= READ_LATENCY; i++) begin
            pipe_idx[i] <= pipe_idx[i-1];
        end
    end

    // a fresh burst at index 0 right after a busy start means the block restarted
    a_start_ignored_when_busy: assert property (
        @(posedge CLOCK) disable iff (!Resetn)
        start && busy |=> !(reading && idx == '0)
    ) else $error("block_fetch: start restarted a block in progress");

endmodule

//--- hw/block_ram.sv
`timescale 1ns/1ps

module block_ram #(
    parameter int WIDTH = 16
) (
    input  logic                 CLOCK,
    input  logic                 wr_en,
    input  idct_pkg::ram_addr_t  wr_addr,
    input  logic [WIDTH-1:0]     wr_data,
    input  idct_pkg::ram_addr_t  rd_addr,
    output logic [WIDTH-1:0]     rd_data
);

    logic [WIDTH-1:0] mem [idct_pkg::BLOCK_WORDS];

    always_ff @(posedge CLOCK) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];   // one cycle read latency
    end

endmodule

//--- hw/idct_core.sv
`timescale 1ns/1ps

module idct_core (
    input  logic                 CLOCK,
    input  logic                 Resetn,
    input  logic                 block_loaded,
    output idct_pkg::ram_addr_t  coeff_rd_addr,
    input  idct_pkg::coeff_t     coeff_rd_data,
    output logic                 t_wr_en,
    output idct_pkg::ram_addr_t  t_wr_addr,
    output idct_pkg::acc_t       t_wr_data,
    output idct_pkg::ram_addr_t  t_rd_addr,
    input  idct_pkg::acc_t       t_rd_data,
    output logic                 pixel_valid,
    output idct_pkg::acc_t       pixel_value,
    output logic                 block_done
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_FILL  = 2'd1;   // first buffer read in flight
    localparam logic [1:0] S_MAC   = 2'd2;
    localparam logic [1:0] S_STORE = 2'd3;   // result strobe visible

    logic [1:0]      state;
    logic            pass;   // 0 builds T from S', 1 streams S out
    logic [2:0]      row;
    logic [2:0]      col;
    logic [2:0]      k;
    logic [2:0]      rd_k;
    logic [5:0]      cos_idx;
    idct_pkg::acc_t  operand;
    idct_pkg::acc_t  product;
    idct_pkg::acc_t  mac_sum;
    idct_pkg::acc_t  acc;

    // the read for k+1 goes out while k is accumulated
    assign rd_k          = (state == S_MAC) ? k + 3'd1 : 3'd0;
    assign coeff_rd_addr = {row, rd_k};   // S'[r][k]
    assign t_rd_addr     = {rd_k, col};   // T[k][c]

    // pass 1 uses C[k][c], pass 2 uses C[k][r] as the transpose
    assign cos_idx = pass ? {k, row} : {k, col};
    assign operand = pass ? t_rd_data : idct_pkg::acc_t'(coeff_rd_data);
    assign product = operand * idct_pkg::acc_t'(idct_pkg::COS_TABLE[cos_idx]);
    assign mac_sum = (k == 3'd0) ? product : acc + product;

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            state       <= S_IDLE;
            pass        <= 1'b0;
            row         <= '0;
            col         <= '0;
            k           <= '0;
            t_wr_en     <= 1'b0;
            pixel_valid <= 1'b0;
            block_done  <= 1'b0;
        end else begin
            t_wr_en     <= 1'b0;
            pixel_valid <= 1'b0;
            block_done  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (block_loaded) begin
                        pass  <= 1'b0;
                        row   <= '0;
                        col   <= '0;
                        state <= S_FILL;
                    end
                end
                S_FILL: begin
                    k     <= '0;
                    state <= S_MAC;
                end
                S_MAC: begin
                    k <= k + 3'd1;
                    if (k == 3'd7) begin
                        t_wr_en     <= !pass;
                        pixel_valid <= pass;
                        state       <= S_STORE;
                    end
                end
                S_STORE: begin
                    col   <= col + 3'd1;
                    state <= S_FILL;
                    if (col == 3'd7) begin
                        row <= row + 3'd1;
                        if (row == 3'd7) begin
                            if (pass) begin   // 64th pixel just went out
                                pass       <= 1'b0;
                                block_done <= 1'b1;
                                state      <= S_IDLE;
                            end else begin
                                pass <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLOCK) begin
        if (state == S_MAC) begin
            acc <= mac_sum;
            if (k == 3'd7) begin
                t_wr_addr   <= {row, col};
                t_wr_data   <= mac_sum >>> idct_pkg::T_SHIFT;
                pixel_value <= mac_sum >>> idct_pkg::S_SHIFT;
            end
        end
    end

    // the fetch must hold off a new block until both passes have finished
    a_no_load_while_running: assert property (
        @(posedge CLOCK) disable iff (!Resetn)
        block_loaded |-> state == S_IDLE
    ) else $error("idct_core: new block loaded while a pass was running");

endmodule

//--- hw/idct_pkg.sv
package idct_pkg;

    localparam int BLOCK_DIM   = 8;
    localparam int BLOCK_WORDS = BLOCK_DIM * BLOCK_DIM;

    // fixed-point scaling after each pass
    localparam int T_SHIFT = 8;
    localparam int S_SHIFT = 16;

    typedef logic [17:0]        sram_addr_t;
    typedef logic signed [15:0] coeff_t;
    typedef logic [5:0]         ram_addr_t;  // row * 8 + column
    typedef logic signed [31:0] acc_t;
    typedef logic signed [11:0] cos_t;

    typedef struct packed {
        logic [7:0] left;   // even column
        logic [7:0] right;  // odd column
    } pixel_pair_t;

    // one SRAM word, a coefficient on the way in and a pixel pair on the way out
    typedef union packed {
        coeff_t      coeff;
        pixel_pair_t pixels;
    } sram_word_u;

    typedef struct packed {
        sram_addr_t address;
        sram_word_u write_data;
        logic       we_n;       // low means write
    } sram_req_t;

    // 2048 * c(k) * cos((2n+1)k*pi/16), entry [k][n] at k*8+n
    localparam cos_t COS_TABLE [0:BLOCK_WORDS-1] = '{
         724,   724,   724,   724,   724,   724,   724,   724,
        1004,   851,   569,   200,  -200,  -569,  -851, -1004,
         946,   392,  -392,  -946,  -946,  -392,   392,   946,
         851,  -200, -1004,  -569,   569,  1004,   200,  -851,
         724,  -724,  -724,   724,   724,  -724,  -724,   724,
         569, -1004,   200,   851,  -851,  -200,  1004,  -569,
         392,  -946,   946,  -392,  -392,   946,  -946,   392,
         200,  -569,   851, -1004,  1004,  -851,   569,  -200
    };

endpackage

//--- hw/idct_top.sv
`timescale 1ns/1ps

module idct_top #(
    parameter int ROW_STRIDE   = 320,
    parameter int READ_LATENCY = 2
) (
    input  logic                   CLOCK,
    input  logic                   Resetn,
    input  logic                   start,
    input  idct_pkg::sram_addr_t   coeff_base,
    input  idct_pkg::sram_addr_t   pixel_base,
    input  idct_pkg::sram_word_u   sram_read_data,
    output idct_pkg::sram_req_t    sram_req,
    output logic                   done
);

    idct_pkg::sram_req_t fetch_req;

    // fetch side of the coefficient buffer
    logic                 fetch_wr_en;
    idct_pkg::ram_addr_t  fetch_wr_addr;
    idct_pkg::coeff_t     fetch_wr_data;
    logic                 block_loaded;

    idct_pkg::ram_addr_t  coeff_rd_addr;
    idct_pkg::coeff_t     coeff_rd_data;

    // intermediate T matrix
    logic                 t_wr_en;
    idct_pkg::ram_addr_t  t_wr_addr;
    idct_pkg::acc_t       t_wr_data;
    idct_pkg::ram_addr_t  t_rd_addr;
    idct_pkg::acc_t       t_rd_data;

    logic                 pixel_valid;
    idct_pkg::acc_t       pixel_value;
    logic                 block_done;

    block_fetch #(
        .ROW_STRIDE   (ROW_STRIDE),
        .READ_LATENCY (READ_LATENCY)
    ) block_fetch_inst (
        .CLOCK          (CLOCK),
        .Resetn         (Resetn),
        .start          (start),
        .coeff_base     (coeff_base),
        .sram_read_data (sram_read_data),
        .fetch_req      (fetch_req),
        .wr_en          (fetch_wr_en),
        .wr_addr        (fetch_wr_addr),
        .wr_data        (fetch_wr_data),
        .block_loaded   (block_loaded)
    );

    block_ram #(.WIDTH(16)) coeff_ram (
        .CLOCK   (CLOCK),
        .wr_en   (fetch_wr_en),
        .wr_addr (fetch_wr_addr),
        .wr_data (fetch_wr_data),
        .rd_addr (coeff_rd_addr),
        .rd_data (coeff_rd_data)
    );

    block_ram #(.WIDTH(32)) t_ram (
        .CLOCK   (CLOCK),
        .wr_en   (t_wr_en),
        .wr_addr (t_wr_addr),
        .wr_data (t_wr_data),
        .rd_addr (t_rd_addr),
        .rd_data (t_rd_data)
    );

    idct_core idct_core_inst (
        .CLOCK         (CLOCK),
        .Resetn        (Resetn),
        .block_loaded  (block_loaded),
        .coeff_rd_addr (coeff_rd_addr),
        .coeff_rd_data (coeff_rd_data),
        .t_wr_en       (t_wr_en),
        .t_wr_addr     (t_wr_addr),
        .t_wr_data     (t_wr_data),
        .t_rd_addr     (t_rd_addr),
        .t_rd_data     (t_rd_data),
        .pixel_valid   (pixel_valid),
        .pixel_value   (pixel_value),
        .block_done    (block_done)
    );

    pixel_writer #(.ROW_STRIDE(ROW_STRIDE)) pixel_writer_inst (
        .CLOCK       (CLOCK),
        .Resetn      (Resetn),
        .pixel_base  (pixel_base),
        .fetch_req   (fetch_req),
        .pixel_valid (pixel_valid),
        .pixel_value (pixel_value),
        .block_done  (block_done),
        .sram_req    (sram_req),
        .done        (done)
    );

endmodule

//--- hw/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer #(
    parameter int ROW_STRIDE = 320
) (
    input  logic                  CLOCK,
    input  logic                  Resetn,
    input  idct_pkg::sram_addr_t  pixel_base,
    input  idct_pkg::sram_req_t   fetch_req,
    input  logic                  pixel_valid,
    input  idct_pkg::acc_t        pixel_value,
    input  logic                  block_done,
    output idct_pkg::sram_req_t   sram_req,
    output logic                  done
);

    idct_pkg::ram_addr_t     pix_idx;      // row-major pixel count
    logic [7:0]              clipped;
    logic [7:0]              left_pixel;   // even column waits for its partner
    logic                    wr_we_n;
    idct_pkg::sram_addr_t    wr_address;
    idct_pkg::pixel_pair_t   wr_pair;

    function automatic logic [7:0] clip_pixel(input idct_pkg::acc_t value);
        if (value < 0)
            return 8'd0;
        else if (value > 255)
            return 8'd255;
        return value[7:0];
    endfunction

    assign clipped = clip_pixel(pixel_value);

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            pix_idx <= '0;
            wr_we_n <= 1'b1;
            done    <= 1'b0;
        end else begin
            done    <= block_done;
            wr_we_n <= !(pixel_valid && pix_idx[0]);   // write on every odd pixel
            if (pixel_valid)
                pix_idx <= pix_idx + 1'b1;
        end
    end

    always_ff @(posedge CLOCK) begin
        if (pixel_valid) begin
            if (!pix_idx[0]) begin
                left_pixel <= clipped;
            end else begin
                wr_pair.left  <= left_pixel;
                wr_pair.right <= clipped;
                wr_address    <= pixel_base
                               + idct_pkg::sram_addr_t'(pix_idx[5:3] * ROW_STRIDE)
                               + idct_pkg::sram_addr_t'(pix_idx[2:1]);   // column / 2
            end
        end
    end

    // writer takes the port for one cycle, otherwise the fetch drives it
    always_comb begin
        sram_req = fetch_req;
        if (!wr_we_n) begin
            sram_req.address           = wr_address;
            sram_req.write_data.pixels = wr_pair;
            sram_req.we_n              = 1'b0;
        end
    end

    // a stepping fetch address means a read burst is in flight
    a_no_write_during_fetch: assert property (
        @(posedge CLOCK) disable iff (!Resetn)
        !wr_we_n |-> $stable(fetch_req.address)
    ) else $error("pixel_writer: write collided with a fetch read burst");

endmodule

//--- idct.f
hw/idct_pkg.sv
hw/block_ram.sv
hw/block_fetch.sv
hw/idct_core.sv
hw/pixel_writer.sv
hw/idct_top.sv
dv/clock_gen.sv
dv/sram_model.sv
dv/tb_idct.sv
